/* cmd_issue.sv */
`timescale 1ns/1ps

module cmd_issue import flash_cmd_pkg::*, flash_seq_pkg::*; (
  input  logic       CLK1,
  input  logic       rst_n,
  input  logic       i_cmd_ready,
  input  cmd_req_t   i_prog_req,
  input  cmd_req_t   i_read_req,
  output flash_cmd_t o_cmd,
  output logic       o_cmd_dv,
  output logic       o_ready_q,
  output flash_op_e  o_prev_op
);

  cmd_req_t req;

  // Only one sequencer runs at a time and the program side takes priority
  assign req = i_prog_req.valid ? i_prog_req : i_read_req;

  // Engine ready is ignored during the strobe cycle as it has not dropped yet
  assign o_ready_q = i_cmd_ready && !o_cmd_dv;

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_cmd     <= '{op: NO_COMMAND, addr: '0};
      o_prev_op <= NO_COMMAND;
      o_cmd_dv  <= 1'b0;
    end else begin
      o_cmd_dv <= req.valid; // Strobe lasts exactly one cycle per request
      if (req.valid) begin
        o_cmd.op <= req.op;
        if (req.rec_prev) o_prev_op <= req.op;
        case (req.addr_op)
          FEATURE:     o_cmd.addr.feat.addr <= req.feat_addr;
          PAGE:        o_cmd.addr.row <= PAGE_ADDR;
          COLUMN_ZERO: o_cmd.addr.column.col <= '0;
          SET_DATA: begin
            // Data byte follows the feature the last check was aimed at
            if (o_cmd.addr.feat.addr == FEAT_BLOCK_LOCK) o_cmd.addr.feat.data <= LOCK_EXPECTED;
            else if (o_cmd.addr.feat.addr == FEAT_CONF) o_cmd.addr.feat.data <= CONF_EXPECTED;
          end
          default: ; // KEEP leaves the word as it is
        endcase
      end
    end
  end

endmodule

/* flash_cmd_pkg.sv */
package flash_cmd_pkg;

  // SPI NAND opcodes as they go out on the wire
  typedef enum logic [7:0] {
    NO_COMMAND    = 8'h00,
    RESET         = 8'hFF,
    GET_FEATURE   = 8'h0F,
    SET_FEATURE   = 8'h1F,
    WRITE_ENABLE  = 8'h06,
    WRITE_DISABLE = 8'h04,
    PROG_LOAD     = 8'h02, // Loads the chip cache from the FIFO
    PROG_EXEC     = 8'h10, // Moves the cache into the page array
    PAGE_READ     = 8'h13, // Moves the page array into the cache
    CACHE_READ    = 8'h03
  } flash_op_e;

  // Feature register addresses used by GET_FEATURE and SET_FEATURE
  localparam logic [7:0] FEAT_BLOCK_LOCK = 8'hA0;
  localparam logic [7:0] FEAT_CONF       = 8'hB0;
  localparam logic [7:0] FEAT_STATUS     = 8'hC0;

  localparam logic [7:0] CONF_EXPECTED = 8'h10; // Normal mode with ECC on and full drive strength
  localparam logic [7:0] LOCK_EXPECTED = 8'h00; // Every block unlocked

  // Bit positions inside the status byte
  localparam int STATUS_OIP   = 0; // Operation in progress
  localparam int STATUS_WEL   = 1; // Write enable latch
  localparam int STATUS_PFAIL = 3; // Program failed
  localparam int STATUS_CRBSY = 7; // Cache read busy

  // One 24-bit address word that each command family reads differently
  typedef union packed {
    logic [23:0] row; // PAGE_READ, PROG_EXEC
    struct packed {
      logic [7:0] rsvd;
      logic [7:0] addr;
      logic [7:0] data;
    } feat; // Features
    struct packed {
      logic [10:0] rsvd;
      logic [12:0] col;
    } column; // PROG_LOAD, CACHE_READ
  } flash_addr_u;

  typedef struct packed {
    flash_op_e   op;
    flash_addr_u addr;
  } flash_cmd_t;

endpackage

/* flash_seq.f */
flash_cmd_pkg.sv
flash_seq_pkg.sv
mode_ctrl.sv
program_seq.sv
read_seq.sv
cmd_issue.sv
flash_seq_top.sv
flash_seq_properties.sv
tb_flash_seq.sv

/* flash_seq_pkg.sv */
package flash_seq_pkg;

  // Top-level modes of one store-and-forward run
  typedef enum logic [2:0] {
    IDLE,
    BUFFER,   // FIFO fills from the host side
    PROGRAM,  // FIFO contents go into the flash page
    READBACK, // Page comes back into the FIFO
    DRAIN     // FIFO empties towards the host
  } seq_mode_e;

  localparam logic [23:0] PAGE_ADDR = 24'h000310; // Page 16 of block 12 with 64 pages to a block
  localparam int XFER_W = 13;
  localparam logic [XFER_W-1:0] XFER_DEFAULT = 13'd2048; // Half a page

  // How cmd_issue updates the held address word alongside a command
  typedef enum logic [2:0] {KEEP, FEATURE, PAGE, COLUMN_ZERO, SET_DATA} addr_op_e;

  typedef struct packed {
    logic                     valid;
    flash_cmd_pkg::flash_op_e op;
    logic                     rec_prev;  // Command also becomes the previous opcode
    addr_op_e                 addr_op;
    logic [7:0]               feat_addr; // Used only with FEATURE
  } cmd_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } feat_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [XFER_W-1:0] size;
  } xfer_upd_t;

endpackage

/* flash_seq_properties.sv */
`timescale 1ns/1ps

module flash_seq_properties import flash_cmd_pkg::*; (
  input logic       CLK1,
  input logic       rst_n,
  input logic       i_cmd_ready,
  input logic       o_cmd_dv,
  input flash_cmd_t o_cmd
);

  int fail_count = 0; // Read by the testbench at the end of the run

  // Every request gives exactly one strobe cycle
  strobe_one_cycle: assert property (@(posedge CLK1) disable iff (!rst_n)
    o_cmd_dv |=> !o_cmd_dv)
    else begin
      $error("o_cmd_dv stayed high for more than one cycle");
      fail_count++;
    end

  // No new command goes out while the engine is busy
  no_strobe_when_busy: assert property (@(posedge CLK1) disable iff (!rst_n)
    !i_cmd_ready |=> !o_cmd_dv)
    else begin
      $error("o_cmd_dv raised while i_cmd_ready was low");
      fail_count++;
    end

  op_changes_with_strobe: assert property (@(posedge CLK1) disable iff (!rst_n)
    !$stable(o_cmd.op) |-> o_cmd_dv) // Opcode only moves together with a strobe
    else begin
      $error("o_cmd.op changed without a strobe");
      fail_count++;
    end

endmodule

bind cmd_issue flash_seq_properties u_props (
  .CLK1(CLK1), .rst_n(rst_n), .i_cmd_ready(i_cmd_ready), .o_cmd_dv(o_cmd_dv), .o_cmd(o_cmd)
);

/* flash_seq_top.sv */
`timescale 1ns/1ps

module flash_seq_top import flash_cmd_pkg::*, flash_seq_pkg::*; (
  input  logic              CLK1,
  input  logic              rst_n,
  input  logic              i_start_n,
  input  logic              i_cmd_ready,
  input  feat_rsp_t         i_feat,
  input  logic [XFER_W-1:0] i_fifo_count,
  input  logic              i_drain_busy,
  input  xfer_upd_t         i_xfer,
  output flash_cmd_t        o_cmd,
  output logic              o_cmd_dv,
  output logic              o_mem_power,
  output logic              o_trig_wr,
  output logic              o_trig_rd
);

  seq_mode_e         mode;      // Observed by the testbench
  logic              prog_run;
  logic              read_run;
  logic              prog_done;
  logic              read_done;
  logic              ready_q;   // Engine ready with the strobe cycle masked
  logic [XFER_W-1:0] xfer_size;
  cmd_req_t          prog_req;
  cmd_req_t          read_req;
  flash_op_e         prev_op;

  mode_ctrl u_mode_ctrl (
    .CLK1(CLK1), .rst_n(rst_n), .i_start_n(i_start_n), .i_fifo_count(i_fifo_count),
    .i_drain_busy(i_drain_busy), .i_xfer(i_xfer), .i_prog_done(prog_done),
    .i_read_done(read_done), .i_cmd_ready(i_cmd_ready), .o_mode(mode),
    .o_prog_run(prog_run), .o_read_run(read_run), .o_xfer_size(xfer_size),
    .o_mem_power(o_mem_power), .o_trig_wr(o_trig_wr), .o_trig_rd(o_trig_rd)
  );

  program_seq u_program_seq (
    .CLK1(CLK1), .rst_n(rst_n), .i_run(prog_run), .i_ready(ready_q), .i_feat(i_feat),
    .i_fifo_count(i_fifo_count), .i_prev_op(prev_op), .i_addr(o_cmd.addr),
    .o_req(prog_req), .o_done(prog_done)
  );

  read_seq u_read_seq (
    .CLK1(CLK1), .rst_n(rst_n), .i_run(read_run), .i_ready(ready_q), .i_feat(i_feat),
    .i_fifo_count(i_fifo_count), .i_xfer_size(xfer_size), .i_prev_op(prev_op),
    .o_req(read_req), .o_done(read_done)
  );

  cmd_issue u_cmd_issue (
    .CLK1(CLK1), .rst_n(rst_n), .i_cmd_ready(i_cmd_ready), .i_prog_req(prog_req),
    .i_read_req(read_req), .o_cmd(o_cmd), .o_cmd_dv(o_cmd_dv), .o_ready_q(ready_q),
    .o_prev_op(prev_op)
  );

endmodule

/* mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl import flash_seq_pkg::*; (
  input  logic              CLK1,
  input  logic              rst_n,
  input  logic              i_start_n,    // Push button, low while pressed
  input  logic [XFER_W-1:0] i_fifo_count,
  input  logic              i_drain_busy, // Engine is still reading the FIFO
  input  xfer_upd_t         i_xfer,
  input  logic              i_prog_done,
  input  logic              i_read_done,
  input  logic              i_cmd_ready,
  output seq_mode_e         o_mode,
  output logic              o_prog_run,
  output logic              o_read_run,
  output logic [XFER_W-1:0] o_xfer_size,
  output logic              o_mem_power,
  output logic              o_trig_wr,
  output logic              o_trig_rd
);

  // Sequencers only run once the chip has supply
  assign o_prog_run = (o_mode == PROGRAM) && o_mem_power;
  assign o_read_run = (o_mode == READBACK) && o_mem_power;
  assign o_trig_wr  = (o_mode == PROGRAM);  // Scope trigger for the write phase
  assign o_trig_rd  = (o_mode == READBACK); // Scope trigger for the read phase

  // The size can be rewritten several times during a host message and the last one wins
  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_xfer_size <= XFER_DEFAULT;
    end else if (i_xfer.valid) begin
      o_xfer_size <= i_xfer.size;
    end
  end

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_mode      <= IDLE;
      o_mem_power <= 1'b0;
    end else begin
      case (o_mode)
        IDLE: begin
          o_mem_power <= 1'b0; // Chip stays unpowered between runs
          if (!i_start_n) begin
            o_mode      <= BUFFER;
            o_mem_power <= 1'b1; // Give the supply time to settle while the FIFO fills
          end
        end
        BUFFER: begin
          // Wait for a full transfer and for the button to be let go
          if (i_fifo_count >= o_xfer_size && i_start_n) o_mode <= PROGRAM;
        end
        PROGRAM: begin
          if (i_prog_done) o_mode <= READBACK;
        end
        READBACK: begin
          if (i_read_done) o_mode <= DRAIN;
        end
        DRAIN: begin
          if (i_cmd_ready) o_mem_power <= 1'b0; // Cut power only with the SPI side idle
          // A read from the FIFO in flight must finish before going idle
          if (i_fifo_count == '0 && !i_drain_busy) o_mode <= IDLE;
        end
        default: o_mode <= IDLE;
      endcase
    end
  end

endmodule

/* program_seq.sv */
`timescale 1ns/1ps

module program_seq import flash_cmd_pkg::*, flash_seq_pkg::*; (
  input  logic              CLK1,
  input  logic              rst_n,
  input  logic              i_run,
  input  logic              i_ready,
  input  feat_rsp_t         i_feat,
  input  logic [XFER_W-1:0] i_fifo_count,
  input  flash_op_e         i_prev_op,
  input  flash_addr_u       i_addr,       // Address word currently held in cmd_issue
  output cmd_req_t          o_req,
  output logic              o_done
);

  localparam logic [2:0] P_RESET     = 3'd0;
  localparam logic [2:0] P_CHECK     = 3'd1; // Issue GET_FEATURE
  localparam logic [2:0] P_EVAL      = 3'd2; // Wait for the feature byte and decide
  localparam logic [2:0] P_SET_FEAT  = 3'd3;
  localparam logic [2:0] P_WREN      = 3'd4;
  localparam logic [2:0] P_WRDI      = 3'd5;
  localparam logic [2:0] P_LOAD_EXEC = 3'd6;

  logic [2:0] state;
  logic [2:0] eval_next;
  logic [7:0] saved_feat; // Last byte returned by GET_FEATURE
  logic       finish;
  logic       ask_lock;
  logic       ask_conf;
  logic       wel;

  assign wel = i_feat.data[STATUS_WEL];

  // Status not busy right after RESET means the lock check comes next
  assign ask_lock = (i_prev_op == RESET) && (i_addr.feat.addr == FEAT_STATUS) &&
                    !saved_feat[STATUS_OIP];
  assign ask_conf = (i_prev_op inside {GET_FEATURE, SET_FEATURE}) &&
                    (i_addr.feat.addr == FEAT_BLOCK_LOCK);

  always_comb begin
    finish    = 1'b0;
    eval_next = P_CHECK;
    if (i_addr.feat.addr == FEAT_BLOCK_LOCK) begin
      if (i_feat.data != LOCK_EXPECTED) eval_next = P_SET_FEAT;
    end else if (i_addr.feat.addr == FEAT_CONF) begin
      if (i_feat.data != CONF_EXPECTED) eval_next = P_SET_FEAT;
    end else if (i_feat.data[STATUS_OIP] || i_prev_op == RESET) begin
      eval_next = P_CHECK; // Keep polling until the chip settles
    end else if (i_feat.data[STATUS_PFAIL]) begin
      eval_next = P_RESET; // RESET clears the fail flag and the whole sequence restarts
    end else if (!wel && (i_prev_op inside {WRITE_DISABLE, PROG_EXEC}) &&
                 i_fifo_count == '0) begin
      finish    = 1'b1;
      eval_next = P_RESET;
    end else if (wel && i_prev_op == PROG_EXEC && i_fifo_count == '0) begin
      eval_next = P_WRDI;
    end else if (!wel) begin
      eval_next = P_WREN; // Latch must be set before any load
    end else if (i_prev_op == WRITE_DISABLE) begin
      eval_next = P_WRDI; // Disable did not take so it goes out again
    end else if (!(i_prev_op inside {PROG_LOAD, PROG_EXEC})) begin
      eval_next = P_LOAD_EXEC; // Start of the transfer
    end else if (i_prev_op == PROG_LOAD && i_fifo_count == '0) begin
      eval_next = P_LOAD_EXEC; // Load is complete so the page gets committed
    end
  end

  assign o_done = i_run && (state == P_EVAL) && i_feat.valid && finish;

  always_comb begin
    o_req = '{valid: 1'b0, op: NO_COMMAND, rec_prev: 1'b1, addr_op: KEEP, feat_addr: FEAT_STATUS};
    case (state)
      P_RESET: o_req.op = RESET;
      P_CHECK: begin
        o_req.op       = GET_FEATURE;
        o_req.addr_op  = FEATURE;
        o_req.rec_prev = ask_lock || ask_conf; // Status polls leave the previous opcode alone
        if (ask_lock) o_req.feat_addr = FEAT_BLOCK_LOCK;
        else if (ask_conf) o_req.feat_addr = FEAT_CONF;
      end
      P_SET_FEAT: begin
        o_req.op      = SET_FEATURE;
        o_req.addr_op = SET_DATA; // Feature address stays from the failed check
      end
      P_WREN: o_req.op = WRITE_ENABLE;
      P_WRDI: o_req.op = WRITE_DISABLE;
      P_LOAD_EXEC: begin
        o_req.op      = (i_prev_op == PROG_LOAD) ? PROG_EXEC : PROG_LOAD;
        o_req.addr_op = (i_prev_op == PROG_LOAD) ? PAGE : COLUMN_ZERO;
      end
      default: o_req.rec_prev = 1'b0;
    endcase
    o_req.valid = i_run && i_ready && (state != P_EVAL);
  end

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= P_RESET;
      saved_feat <= '0;
    end else if (!i_run) begin
      state <= P_RESET; // Every program run begins with a chip reset
    end else if (state == P_EVAL) begin
      if (i_feat.valid) begin
        saved_feat <= i_feat.data;
        state      <= eval_next;
      end
    end else if (i_ready) begin
      state <= P_CHECK;
      if (state == P_RESET) saved_feat[STATUS_OIP] <= 1'b1; // Busy until a status read says not
      if (state == P_CHECK) state <= P_EVAL;
    end
  end

endmodule

/* read_seq.sv */
`timescale 1ns/1ps

module read_seq import flash_cmd_pkg::*, flash_seq_pkg::*; (
  input  logic              CLK1,
  input  logic              rst_n,
  input  logic              i_run,
  input  logic              i_ready,
  input  feat_rsp_t         i_feat,
  input  logic [XFER_W-1:0] i_fifo_count,
  input  logic [XFER_W-1:0] i_xfer_size,
  input  flash_op_e         i_prev_op,
  output cmd_req_t          o_req,
  output logic              o_done
);

  localparam logic [2:0] R_CHECK = 3'd0;
  localparam logic [2:0] R_EVAL  = 3'd1;
  localparam logic [2:0] R_WRDI  = 3'd2;
  localparam logic [2:0] R_PAGE  = 3'd3;
  localparam logic [2:0] R_CACHE = 3'd4;

  logic [2:0] state;
  logic [2:0] eval_next;
  logic       busy;

  assign busy = i_feat.data[STATUS_OIP] || i_feat.data[STATUS_CRBSY];

  always_comb begin
    eval_next = R_CHECK;
    if (busy) eval_next = R_CHECK;
    else if (i_feat.data[STATUS_WEL]) eval_next = R_WRDI; // Latch must be low while reading
    else if (i_prev_op == PAGE_READ) eval_next = R_CACHE;  // Page sits in the cache now
    else if (i_prev_op != CACHE_READ) eval_next = R_PAGE;  // Fresh read
  end

  // Cache read is over once the whole transfer has arrived in the FIFO
  assign o_done = i_run && (state == R_EVAL) && i_feat.valid && !busy &&
                  !i_feat.data[STATUS_WEL] && (i_prev_op == CACHE_READ) &&
                  (i_fifo_count >= i_xfer_size);

  always_comb begin
    o_req = '{valid: 1'b0, op: GET_FEATURE, rec_prev: 1'b1, addr_op: KEEP, feat_addr: FEAT_STATUS};
    case (state)
      R_CHECK: begin
        o_req.rec_prev = 1'b0;
        o_req.addr_op  = FEATURE;
      end
      R_WRDI: o_req.op = WRITE_DISABLE;
      R_PAGE: begin
        o_req.op      = PAGE_READ;
        o_req.addr_op = PAGE;
      end
      R_CACHE: begin
        o_req.op      = CACHE_READ;
        o_req.addr_op = COLUMN_ZERO; // Start from the first byte of the page
      end
      default: o_req.rec_prev = 1'b0;
    endcase
    o_req.valid = i_run && i_ready && (state != R_EVAL);
  end

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      state <= R_CHECK;
    end else if (!i_run) begin
      state <= R_CHECK;
    end else if (state == R_EVAL) begin
      if (i_feat.valid) state <= eval_next;
    end else if (i_ready) begin
      state <= (state == R_CHECK) ? R_EVAL : R_CHECK; // Every command is followed by a poll
    end
  end

endmodule

/* tb_flash_seq.sv */
`timescale 1ns/1ps

module tb_flash_seq import flash_cmd_pkg::*, flash_seq_pkg::*; ();

  typedef struct packed {
    logic [XFER_W-1:0] size;
    logic [7:0]        lock;        // Block lock byte the chip powers up with
    logic [7:0]        conf;        // Configuration byte the chip powers up with
    logic [3:0]        busy_polls;  // Busy status replies after RESET, PROG_EXEC and PAGE_READ
    logic              inject_fail; // First PROG_EXEC reports a program failure
    logic [7:0]        exp_cmds;    // Strobed commands in the whole run
  } row_t;

  typedef struct packed {
    flash_op_e   op;
    logic [23:0] field; // Address field that matters for this opcode
    logic [1:0]  trig;  // {o_trig_wr, o_trig_rd} at the strobe
  } cmd_rec_t;

  localparam int NROWS = 4;
  localparam int STEP  = 64; // FIFO words moved per cycle
  localparam int LIMIT = 4000 * NROWS;
  localparam logic [1:0] PH_PROG = 2'b10;
  localparam logic [1:0] PH_READ = 2'b01;

  logic              CLK1         = 1'b0;
  logic              rst_n        = 1'b0;
  logic              i_start_n    = 1'b1;
  logic              i_cmd_ready  = 1'b1;
  feat_rsp_t         i_feat       = '0;
  logic [XFER_W-1:0] i_fifo_count = '0;
  logic              i_drain_busy = 1'b0;
  xfer_upd_t         i_xfer       = '0;
  flash_cmd_t        o_cmd;
  logic              o_cmd_dv;
  logic              o_mem_power;
  logic              o_trig_wr;
  logic              o_trig_rd;

  row_t       rows [NROWS];
  int         row_idx = 0;
  cmd_rec_t   seen[$];  // Filled by the engine model
  cmd_rec_t   exp_q[$]; // Filled from the sequencing rules
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  flash_cmd_t pend;     // Command the engine is working on
  int         ready_wait = 0;
  int         busy_left  = 0;
  logic [7:0] lock_b;
  logic [7:0] conf_b;
  logic       wel = 1'b0;
  logic       pfail = 1'b0;
  logic       fail_armed = 1'b0;

  flash_seq_top u_dut (.*);

  always #4 CLK1 = ~CLK1;

  always @(posedge CLK1) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not return to idle within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [23:0] field_of(input flash_cmd_t c);
    case (c.op)
      GET_FEATURE:           field_of = {16'h0, c.addr.feat.addr};
      SET_FEATURE:           field_of = {8'h0, c.addr.feat.addr, c.addr.feat.data};
      PROG_EXEC, PAGE_READ:  field_of = c.addr.row;
      PROG_LOAD, CACHE_READ: field_of = {11'h0, c.addr.column.col};
      default:               field_of = '0;
    endcase
  endfunction

  // The flash engine and the host side of the FIFO drive 1 ns after the edge
  always @(posedge CLK1) begin
    #1;
    i_feat.valid = 1'b0;
    if (u_dut.mode == IDLE) begin // Chip state for the next run comes from the table
      lock_b     = rows[row_idx].lock;
      conf_b     = rows[row_idx].conf;
      fail_armed = rows[row_idx].inject_fail;
    end
    if (o_cmd_dv) begin
      seen.push_back('{op: o_cmd.op, field: field_of(o_cmd), trig: {o_trig_wr, o_trig_rd}});
      pend        = o_cmd;
      i_cmd_ready = 1'b0; // Engine takes the command
      ready_wait  = 2;
      case (o_cmd.op)
        RESET: begin
          busy_left = rows[row_idx].busy_polls;
          wel       = 1'b0;
          pfail     = 1'b0;
        end
        SET_FEATURE: begin
          if (o_cmd.addr.feat.addr == FEAT_BLOCK_LOCK) lock_b = o_cmd.addr.feat.data;
          if (o_cmd.addr.feat.addr == FEAT_CONF) conf_b = o_cmd.addr.feat.data;
        end
        WRITE_ENABLE:  wel = 1'b1;
        WRITE_DISABLE: wel = 1'b0;
        PROG_EXEC: begin
          wel       = 1'b0;
          busy_left = rows[row_idx].busy_polls;
          pfail     = fail_armed; // Only the first execute of the run fails
          fail_armed = 1'b0;
        end
        PAGE_READ: busy_left = rows[row_idx].busy_polls;
        default: ;
      endcase
    end else if (!i_cmd_ready) begin
      if (pend.op == PROG_LOAD) i_fifo_count = (i_fifo_count > STEP) ? i_fifo_count - STEP : '0;
      if (pend.op == CACHE_READ) begin
        if (rows[row_idx].size - i_fifo_count > STEP) i_fifo_count = i_fifo_count + STEP;
        else i_fifo_count = rows[row_idx].size;
      end
      if (ready_wait > 0) ready_wait--;
      if (ready_wait == 0 && !(pend.op == PROG_LOAD && i_fifo_count != '0) &&
          !(pend.op == CACHE_READ && i_fifo_count != rows[row_idx].size)) begin
        i_cmd_ready = 1'b1;
        if (pend.op == GET_FEATURE) begin
          i_feat.valid = 1'b1;
          case (pend.addr.feat.addr)
            FEAT_BLOCK_LOCK: i_feat.data = lock_b;
            FEAT_CONF:       i_feat.data = conf_b;
            default: begin
              i_feat.data               = '0;
              i_feat.data[STATUS_OIP]   = (busy_left != 0);
              i_feat.data[STATUS_WEL]   = wel;
              i_feat.data[STATUS_PFAIL] = pfail;
              if (busy_left != 0) busy_left--;
            end
          endcase
        end
      end
    end
    // Host side fills the FIFO while buffering and empties it while draining
    if (u_dut.mode == BUFFER && i_fifo_count < rows[row_idx].size) begin
      if (rows[row_idx].size - i_fifo_count > STEP) i_fifo_count = i_fifo_count + STEP;
      else i_fifo_count = rows[row_idx].size;
    end
    i_drain_busy = (u_dut.mode == DRAIN) && (i_fifo_count != '0);
    if (i_drain_busy) i_fifo_count = (i_fifo_count > STEP) ? i_fifo_count - STEP : '0;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic add_expected(input flash_op_e op, input logic [23:0] field,
                              input logic [1:0] trig);
    exp_q.push_back('{op: op, field: field, trig: trig});
  endtask

  task automatic build_expected(input row_t row);
    int pass;
    for (pass = 0; pass <= int'(row.inject_fail); pass++) begin
      add_expected(RESET, '0, PH_PROG);
      repeat (row.busy_polls + 1) add_expected(GET_FEATURE, FEAT_STATUS, PH_PROG);
      add_expected(GET_FEATURE, FEAT_BLOCK_LOCK, PH_PROG);
      // A repeated pass finds lock and configuration already corrected
      if (pass == 0 && row.lock != 8'd0) add_expected(SET_FEATURE, {FEAT_BLOCK_LOCK, 8'd0}, PH_PROG);
      add_expected(GET_FEATURE, FEAT_CONF, PH_PROG);
      if (pass == 0 && row.conf != 8'd16) add_expected(SET_FEATURE, {FEAT_CONF, 8'd16}, PH_PROG);
      add_expected(GET_FEATURE, FEAT_STATUS, PH_PROG);
      add_expected(WRITE_ENABLE, '0, PH_PROG);
      add_expected(GET_FEATURE, FEAT_STATUS, PH_PROG);
      add_expected(PROG_LOAD, '0, PH_PROG);
      add_expected(GET_FEATURE, FEAT_STATUS, PH_PROG); // FIFO is empty by now
      add_expected(PROG_EXEC, 24'h000310, PH_PROG);
      repeat (row.busy_polls + 1) add_expected(GET_FEATURE, FEAT_STATUS, PH_PROG);
    end
    add_expected(GET_FEATURE, FEAT_STATUS, PH_READ);
    add_expected(PAGE_READ, 24'h000310, PH_READ);
    repeat (row.busy_polls + 1) add_expected(GET_FEATURE, FEAT_STATUS, PH_READ);
    add_expected(CACHE_READ, '0, PH_READ);
    add_expected(GET_FEATURE, FEAT_STATUS, PH_READ);
  endtask

  task automatic wait_mode(input seq_mode_e m);
    while (u_dut.mode != m) begin
      @(posedge CLK1);
      #1;
    end
  endtask

  initial begin
    int r;
    int i;
    int base;
    int row_err;
    // Columns are size, lock, conf, busy polls, inject fail and expected command count
    rows[0] = '{13'd2048, 8'h00, 8'h10, 4'd0, 1'b0, 8'd16};
    rows[1] = '{13'd100,  8'h38, 8'h10, 4'd2, 1'b0, 8'd23};
    rows[2] = '{13'd16,   8'h00, 8'h00, 4'd1, 1'b1, 8'd33};
    rows[3] = '{13'd513,  8'h7C, 8'h11, 4'd3, 1'b0, 8'd27};
    base = 0;
    repeat (5) @(posedge CLK1);
    #1;
    rst_n = 1'b1;
    @(posedge CLK1);
    #1;
    compare_value("o_cmd_dv", o_cmd_dv, 0);
    compare_value("o_mem_power", o_mem_power, 0);
    compare_value("o_trig_wr", o_trig_wr, 0);
    compare_value("o_trig_rd", o_trig_rd, 0);
    $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
    for (r = 0; r < NROWS; r++) begin
      row_idx = r;
      row_err = errors;
      exp_q.delete();
      build_expected(rows[r]);
      @(posedge CLK1);
      #1;
      i_xfer = '{valid: 1'b1, size: rows[r].size}; // One size update per run
      @(posedge CLK1);
      #1;
      i_xfer.valid = 1'b0;
      i_start_n    = 1'b0;
      wait_mode(BUFFER);
      compare_value("o_mem_power", o_mem_power, 1);
      repeat (3) @(posedge CLK1);
      #1;
      i_start_n = 1'b1;
      wait_mode(IDLE);
      compare_value("o_mem_power", o_mem_power, 0);
      compare_value("o_trig_wr", o_trig_wr, 0);
      compare_value("o_trig_rd", o_trig_rd, 0);
      compare_value("i_fifo_count", i_fifo_count, 0);
      compare_value("cmd_count", seen.size() - base, rows[r].exp_cmds);
      for (i = 0; i < exp_q.size() && base + i < seen.size(); i++) begin
        compare_value($sformatf("o_cmd[%0d].op", i), seen[base + i].op, exp_q[i].op);
        compare_value($sformatf("o_cmd[%0d].addr", i), seen[base + i].field, exp_q[i].field);
        compare_value($sformatf("trig[%0d]", i), seen[base + i].trig, exp_q[i].trig);
      end
      $display("row %0d: size %0d, %0d commands, %s", r, rows[r].size,
               seen.size() - base, (errors == row_err) ? "ok" : "mismatch");
      base = seen.size();
    end
    $display("rows %0d, checks %0d, errors %0d, assertion failures %0d", NROWS, checks,
             errors, u_dut.u_cmd_issue.u_props.fail_count);
    if (errors == 0 && u_dut.u_cmd_issue.u_props.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
